//--- sources.f
logic/mouse_pkg.sv
logic/stick_pkg.sv
logic/mouse_packet_decoder.sv
logic/mouse_stick_emulator.sv
logic/stick_port_mapper.sv
logic/analog_stick_top.sv
tests/stick_asserts.sv
tests/stick_checker.sv
tests/tb_analog_stick.sv

//--- run_sim.sh
#!/bin/sh
# build the testbench with Verilator, run it, then scan the log
verilator --binary --timing --assert -Wno-fatal --top-module tb_analog_stick \
	-f sources.f -o tb_analog_stick > build.log 2>&1 || { cat build.log; exit 1; }
./obj_dir/tb_analog_stick > sim.log 2>&1
cat sim.log
grep -q "Checks failed" sim.log && { echo "simulation reported mismatches"; exit 1; } || \
	grep -q "All checks passed" sim.log || { echo "simulation ended early"; exit 1; }

//--- tests/tb_analog_stick.sv
`timescale 1ns/1ps

module tb_analog_stick;

	import mouse_pkg::*;
	import stick_pkg::*;

	// ========================================
	// run length
	// ========================================

	localparam int CLK_PERIOD = 4;
	localparam int WIN_CYCLES = 8;
	// windows per test kind
	localparam int N_PHYS  = 6;
	localparam int N_MOUSE = 40;
	localparam int N_CLEAR = 7;
	// reset window, then each kind without and with swap
	localparam int N_WINDOWS = 1 + 2 * (N_PHYS + N_MOUSE + N_CLEAR);
	localparam int RUN_NS    = (3 + N_WINDOWS * WIN_CYCLES) * CLK_PERIOD;

	typedef struct packed {
		core_port_t p1;
		core_port_t p2;
	} port_pair_t;

	logic          clk_sys;
	logic          rst_n;
	mouse_packet_t mouse_pkt;
	stick_phys_t   joy_a;
	stick_phys_t   joy_b;
	logic          mouse_disable;
	logic          swap_ports;
	logic          reset_req;
	core_port_t    port_1;
	core_port_t    port_2;
	// checker side
	port_pair_t    expected;
	logic          check_now;
	logic          test_end;
	int            test_id;
	int            check_total;
	int            err_total;
	// model state, lfsr and the packet on the bus
	logic          m_emul;
	logic          m_toggle;
	int            m_x;
	int            m_y;
	logic [15:0]   lfsr;
	mouse_packet_t cur_pkt;

	analog_stick_top u_dut (.*);

	stick_checker u_checker (
		.*,
		.exp_1 (expected.p1),
		.exp_2 (expected.p2)
	);

	initial begin
		clk_sys = 1'b0;
		forever begin
			#(CLK_PERIOD / 2);
			clk_sys = ~clk_sys;
		end
	end

	// full run plus a quarter
	initial begin
		#(RUN_NS + RUN_NS / 4);
		$display("watchdog timeout: tests still running after %0d ns", RUN_NS + RUN_NS / 4);
		$display("Checks failed");
		$finish;
	end

	// ========================================
	// random bits and reference model
	// ========================================

	// 16-bit fibonacci lfsr, taps 16 14 13 11, one step per bit
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = {lfsr[14:0], lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10]};
			v = {v[30:0], lfsr[0]};
		end
		return v;
	endfunction

	function automatic int limit(input int v, input int lo, input int hi);
		if (v < lo) begin
			return lo;
		end
		if (v > hi) begin
			return hi;
		end
		return v;
	endfunction

	// offset binary, direction reversed, upper nibble repeated below
	function automatic core_axis_t core_code(input int a);
		int c;
		c = 127 - a;
		return core_axis_t'(c * 16 + c / 16);
	endfunction

	function automatic core_port_t port_value(input int x, input int y, input logic fire);
		core_port_t p;
		p.x      = core_code(x);
		p.y      = core_code(y);
		p.fire_n = !fire;
		return p;
	endfunction

	// one window of stimulus in, both expected ports out
	function automatic port_pair_t expect_ports(input mouse_packet_t pkt,
		input stick_phys_t ja, input stick_phys_t jb,
		input logic mdis, input logic swp, input logic rreq);
		port_pair_t r;
		core_port_t prim;
		core_port_t sec;
		int dx;
		int dy;
		dx = pkt.x_sign ? int'(pkt.x_move) - 128 : int'(pkt.x_move);
		dy = pkt.y_sign ? int'(pkt.y_move) - 128 : int'(pkt.y_move);
		dx = limit(dx, -MOUSE_STEP_LIMIT, MOUSE_STEP_LIMIT);
		dy = limit(dy, -MOUSE_STEP_LIMIT, MOUSE_STEP_LIMIT);
		// clear beats a packet in the same window
		if (ja.buttons != 16'h0 || mdis || rreq) begin
			m_emul = 1'b0;
			m_x    = 0;
			m_y    = 0;
		end else if (pkt.toggle != m_toggle) begin
			m_emul = 1'b1;
			m_x    = limit(m_x + dx, STICK_POS_MIN, STICK_POS_MAX);
			// screen y runs opposite to mouse y
			m_y    = limit(m_y - dy, STICK_POS_MIN, STICK_POS_MAX);
		end
		m_toggle = pkt.toggle;
		if (m_emul) begin
			prim = port_value(m_x, m_y, pkt.buttons != 2'b00);
		end else begin
			prim = port_value(int'(ja.x), int'(ja.y), ja.buttons[FIRE_BIT]);
		end
		sec  = port_value(int'(jb.x), int'(jb.y), jb.buttons[FIRE_BIT]);
		r.p1 = swp ? sec : prim;
		r.p2 = swp ? prim : sec;
		return r;
	endfunction

	// ========================================
	// stimulus
	// ========================================

	// flipped toggle; phases 8..21 push right and up, 22 on left and down
	function automatic mouse_packet_t new_packet(input int phase);
		logic [31:0] r;
		mouse_packet_t p;
		r = rand_bits(25);
		p = r[24:0];
		p.toggle = !cur_pkt.toggle;
		if (phase >= 8) begin
			p.x_sign    = phase >= 22;
			p.y_sign    = phase >= 22;
			p.x_move[6] = phase < 22;
			p.y_move[6] = phase < 22;
		end
		return p;
	endfunction

	// kind 0 reset, 1 physical, 2 mouse, 3 clearing
	task automatic run_test(input int kind, input int n, input logic swp, input logic closes);
		stick_phys_t ja;
		stick_phys_t jb;
		logic [31:0] r;
		logic        mdis;
		logic        rreq;
		port_pair_t  e;
		for (int i = 0; i < n; i++) begin
			ja = rand_bits(32);
			jb = rand_bits(32);
			r  = rand_bits(4);
			if (kind != 1) begin
				ja.buttons = '0;
			end
			// clear sources on odd windows: buttons, mouse off, soft reset
			if (kind == 3 && i == 1) begin
				ja.buttons = 16'h0001 << r[3:0];
			end
			if (kind == 0) begin
				ja = '0;
				jb = '0;
			end
			if (kind >= 2) begin
				cur_pkt = new_packet(kind == 2 ? i : 0);
			end
			mdis = kind == 1 || (kind == 3 && i == 3);
			rreq = kind == 3 && i == 5;
			e    = expect_ports(cur_pkt, ja, jb, mdis, swp, rreq);
			mouse_pkt     <= cur_pkt;
			joy_a         <= ja;
			joy_b         <= jb;
			mouse_disable <= mdis;
			reset_req     <= rreq;
			swap_ports    <= swp;
			expected      <= e;
			repeat (WIN_CYCLES - 1) @(posedge clk_sys);
			check_now <= 1'b1;
			test_end  <= closes && i == n - 1;
			@(posedge clk_sys);
			check_now <= 1'b0;
			test_end  <= 1'b0;
		end
	endtask

	initial begin
		rst_n         = 1'b0;
		mouse_pkt     = '0;
		joy_a         = '0;
		joy_b         = '0;
		mouse_disable = 1'b0;
		swap_ports    = 1'b0;
		reset_req     = 1'b0;
		expected      = '0;
		check_now     = 1'b0;
		test_end      = 1'b0;
		test_id       = 0;
		m_emul        = 1'b0;
		m_toggle      = 1'b0;
		m_x           = 0;
		m_y           = 0;
		lfsr          = 16'd98;
		cur_pkt       = '0;
		repeat (3) @(posedge clk_sys);
		rst_n   <= 1'b1;
		test_id <= 1;
		run_test(0, 1, 1'b0, 1'b1);
		test_id <= 2;
		run_test(1, N_PHYS, 1'b0, 1'b1);
		test_id <= 3;
		run_test(2, N_MOUSE, 1'b0, 1'b1);
		test_id <= 4;
		run_test(3, N_CLEAR, 1'b0, 1'b1);
		// same three again, ports exchanged
		test_id <= 5;
		run_test(1, N_PHYS, 1'b1, 1'b0);
		run_test(2, N_MOUSE, 1'b1, 1'b0);
		run_test(3, N_CLEAR, 1'b1, 1'b1);
		$display("tests: 5, checks: %0d, mismatches: %0d", check_total, err_total);
		if (err_total == 0) begin
			$display("All checks passed");
		end else begin
			$display("Checks failed");
		end
		$finish;
	end

endmodule

//--- tests/stick_checker.sv
`timescale 1ns/1ps

module stick_checker (
	input  logic                  clk_sys,
	input  logic                  rst_n,
	input  logic                  check_now,
	input  logic                  test_end,
	input  int                    test_id,
	input  stick_pkg::core_port_t port_1,
	input  stick_pkg::core_port_t port_2,
	input  stick_pkg::core_port_t exp_1,
	input  stick_pkg::core_port_t exp_2,
	output int                    check_total,
	output int                    err_total
);

	import stick_pkg::*;

	// run totals, then counts for the current test
	int n_checks = 0;
	int n_errs   = 0;
	int t_checks = 0;
	int t_errs   = 0;

	assign check_total = n_checks;
	assign err_total   = n_errs;

	// whole port at once, every field shown on a mismatch
	task automatic compare_port(input string name, input core_port_t got, input core_port_t want);
		n_checks++;
		t_checks++;
		if (got !== want) begin
			n_errs++;
			t_errs++;
			$display("Error at %0t: test %0d %s x=%h y=%h fire_n=%b, expected x=%h y=%h fire_n=%b",
				$time, test_id, name, got.x, got.y, got.fire_n, want.x, want.y, want.fire_n);
		end
	endtask

	// mid cycle after the window's last edge, ports long settled
	always @(negedge clk_sys) begin
		if (rst_n === 1'b1 && check_now === 1'b1) begin
			compare_port("port_1", port_1, exp_1);
			compare_port("port_2", port_2, exp_2);
		end
		if (rst_n === 1'b1 && test_end === 1'b1) begin
			$display("test %0d finished: %0d checks, %0d mismatches", test_id, t_checks, t_errs);
			t_checks = 0;
			t_errs   = 0;
		end
	end

endmodule

//--- tests/stick_asserts.sv
`timescale 1ns/1ps

module stick_asserts (
	input logic                   clk_sys,
	input logic                   rst_n,
	input logic                   move_stb,
	input mouse_pkg::mouse_move_t move,
	input logic                   clear,
	input logic                   reset_req,
	input logic                   emulating,
	input stick_pkg::stick_axis_t pos_x,
	input stick_pkg::stick_axis_t pos_y
);

	// a step never wraps x past a limit, so it keeps the delta's direction
	x_no_wrap: assert property (@(posedge clk_sys) disable iff (!rst_n)
		move_stb && !clear |=>
		($past(move.dx[8]) ? (pos_x <= $past(pos_x)) : (pos_x >= $past(pos_x))))
		else $error("emulated x position wrapped past a limit");

	// y runs against the mouse, same no wrap rule
	y_no_wrap: assert property (@(posedge clk_sys) disable iff (!rst_n)
		move_stb && !clear |=>
		($past(move.dy[8]) ? (pos_y >= $past(pos_y)) : (pos_y <= $past(pos_y))))
		else $error("emulated y position wrapped past a limit");

	// packets toggle a window apart, so a second strobe has no toggle change behind it
	single_strobe: assert property (@(posedge clk_sys) disable iff (!rst_n)
		move_stb |=> !move_stb)
		else $error("move strobe high two cycles running");

	// soft reset drops emulation one edge later
	reset_clears: assert property (@(posedge clk_sys) disable iff (!rst_n)
		reset_req |=> !emulating)
		else $error("emulation still on after reset request");

endmodule

bind mouse_stick_emulator stick_asserts u_asserts (
	.clk_sys   (clk_sys),
	.rst_n     (rst_n),
	.move_stb  (move_stb),
	.move      (move),
	.clear     (clear),
	.reset_req (reset_req),
	.emulating (emulating),
	.pos_x     (pos_x),
	.pos_y     (pos_y)
);

//--- logic/analog_stick_top.sv
`timescale 1ns/1ps

module analog_stick_top (
	input  logic                     clk_sys,
	input  logic                     rst_n,
	input  mouse_pkg::mouse_packet_t mouse_pkt,
	input  stick_pkg::stick_phys_t   joy_a,
	input  stick_pkg::stick_phys_t   joy_b,
	input  logic                     mouse_disable,
	input  logic                     swap_ports,
	input  logic                     reset_req,
	output stick_pkg::core_port_t    port_1,
	output stick_pkg::core_port_t    port_2
);

	import mouse_pkg::*;
	import stick_pkg::*;

	// ========================================
	// stage links
	// ========================================

	// decoder to emulator
	logic        move_stb;
	mouse_move_t move;

	// emulator to mapper
	stick_primary_t stick_primary;

	// packet decode, one strobe per toggle change
	mouse_packet_decoder u_decoder (
		.clk_sys   (clk_sys),
		.rst_n     (rst_n),
		.mouse_pkt (mouse_pkt),
		.move_stb  (move_stb),
		.move      (move)
	);

	// position integration and primary stick select
	mouse_stick_emulator u_emulator (
		.clk_sys       (clk_sys),
		.rst_n         (rst_n),
		.move_stb      (move_stb),
		.move          (move),
		.mouse_buttons (mouse_pkt.buttons),
		.joy_a         (joy_a),
		.mouse_disable (mouse_disable),
		.reset_req     (reset_req),
		.primary       (stick_primary)
	);

	// core format and port swap
	stick_port_mapper u_mapper (
		.clk_sys    (clk_sys),
		.rst_n      (rst_n),
		.primary    (stick_primary),
		.joy_b      (joy_b),
		.swap_ports (swap_ports),
		.port_1     (port_1),
		.port_2     (port_2)
	);

endmodule

//--- logic/stick_port_mapper.sv
`timescale 1ns/1ps

module stick_port_mapper (
	input  logic                      clk_sys,
	input  logic                      rst_n,
	input  stick_pkg::stick_primary_t primary,
	input  stick_pkg::stick_phys_t    joy_b,
	input  logic                      swap_ports,
	output stick_pkg::core_port_t     port_1,
	output stick_pkg::core_port_t     port_2
);

	import stick_pkg::*;

	// ========================================
	// axis conversion
	// ========================================

	// flip the top bit for offset binary, then invert the direction
	// upper nibble repeated below to stretch 8 bits over 12
	function automatic core_axis_t to_core_axis(input stick_axis_t a);
		logic [7:0] code;
		code = 8'hFF - {~a[7], a[6:0]};
		return {code, code[7:4]};
	endfunction

	// full port value, fire goes active low
	function automatic core_port_t to_core_port(
		input stick_axis_t x,
		input stick_axis_t y,
		input logic        fire
	);
		core_port_t p;
		p.x      = to_core_axis(x);
		p.y      = to_core_axis(y);
		p.fire_n = ~fire;
		return p;
	endfunction

	// ========================================
	// per stick core values
	// ========================================

	// primary stick, mouse or joystick 1
	core_port_t prim_port;
	// second physical stick
	core_port_t joyb_port;

	assign prim_port = to_core_port(primary.x, primary.y, primary.fire);
	assign joyb_port = to_core_port(joy_b.x, joy_b.y, joy_b.buttons[FIRE_BIT]);

	// ========================================
	// port routing
	// ========================================

	// ports come out of reset centred with fire released
	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			port_1 <= CORE_PORT_IDLE;
			port_2 <= CORE_PORT_IDLE;
		end else if (swap_ports) begin
			// exchanged
			port_1 <= joyb_port;
			port_2 <= prim_port;
		end else begin
			// normal order
			port_1 <= prim_port;
			port_2 <= joyb_port;
		end
	end

endmodule

//--- logic/mouse_stick_emulator.sv
`timescale 1ns/1ps

module mouse_stick_emulator (
	input  logic                      clk_sys,
	input  logic                      rst_n,
	input  logic                      move_stb,
	input  mouse_pkg::mouse_move_t    move,
	input  logic [1:0]                mouse_buttons,
	input  stick_pkg::stick_phys_t    joy_a,
	input  logic                      mouse_disable,
	input  logic                      reset_req,
	output stick_pkg::stick_primary_t primary
);

	import stick_pkg::*;

	// ========================================
	// position state
	// ========================================

	// set by the first packet, dropped by any clear source
	logic        emulating;
	stick_axis_t pos_x;
	stick_axis_t pos_y;

	// wide sums, room for one step past either limit
	logic signed [9:0] sum_x;
	logic signed [9:0] sum_y;

	// clear sources
	logic clear;

	// x follows the mouse, y is flipped to screen sense
	assign sum_x = {{2{pos_x[7]}}, pos_x} + {move.dx[8], move.dx};
	assign sum_y = {{2{pos_y[7]}}, pos_y} - {move.dy[8], move.dy};

	// real stick activity, soft reset or mouse off
	assign clear = (|joy_a.buttons) | reset_req | mouse_disable;

	// clip a wide sum back into the axis range
	function automatic stick_axis_t saturate(input logic signed [9:0] v);
		if (v < STICK_POS_MIN) begin
			return stick_axis_t'(STICK_POS_MIN);
		end
		if (v > STICK_POS_MAX) begin
			return stick_axis_t'(STICK_POS_MAX);
		end
		return v[7:0];
	endfunction

	// clear takes priority over a strobe in the same cycle
	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			emulating <= 1'b0;
			pos_x     <= '0;
			pos_y     <= '0;
		end else if (clear) begin
			emulating <= 1'b0;
			pos_x     <= '0;
			pos_y     <= '0;
		end else if (move_stb) begin
			emulating <= 1'b1;
			pos_x     <= saturate(sum_x);
			pos_y     <= saturate(sum_y);
		end
	end

	// ========================================
	// primary stick select
	// ========================================

	stick_primary_t primary_next;

	always_comb begin
		if (emulating) begin
			primary_next.x    = pos_x;
			primary_next.y    = pos_y;
			// either mouse button fires
			primary_next.fire = |mouse_buttons;
		end else begin
			primary_next.x    = joy_a.x;
			primary_next.y    = joy_a.y;
			primary_next.fire = joy_a.buttons[FIRE_BIT];
		end
	end

	// registered, one cycle behind the position
	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			primary <= '0;
		end else begin
			primary <= primary_next;
		end
	end

endmodule

//--- logic/mouse_packet_decoder.sv
`timescale 1ns/1ps

module mouse_packet_decoder (
	input  logic                    clk_sys,
	input  logic                    rst_n,
	input  mouse_pkg::mouse_packet_t mouse_pkt,
	output logic                    move_stb,
	output mouse_pkg::mouse_move_t   move
);

	import mouse_pkg::*;

	// ========================================
	// packet detection
	// ========================================

	// toggle seen on the previous edge
	logic toggle_q;
	logic pkt_new;

	// any change of the toggle means a fresh packet
	assign pkt_new = mouse_pkt[MOUSE_TOGGLE_BIT] != toggle_q;

	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			toggle_q <= 1'b0;
		end else begin
			toggle_q <= mouse_pkt[MOUSE_TOGGLE_BIT];
		end
	end

	// ========================================
	// delta extraction
	// ========================================

	// sign extend a 7-bit field, then limit to +-MOUSE_STEP_LIMIT
	function automatic mouse_delta_t clamp_step(
		input logic                     sign,
		input logic [MOUSE_FIELD_W-1:0] field
	);
		mouse_delta_t raw;
		raw = {sign, sign, field};
		if (raw > MOUSE_STEP_LIMIT) begin
			return mouse_delta_t'(MOUSE_STEP_LIMIT);
		end
		if (raw < -MOUSE_STEP_LIMIT) begin
			return mouse_delta_t'(-MOUSE_STEP_LIMIT);
		end
		return raw;
	endfunction

	mouse_move_t move_next;

	always_comb begin
		move_next.dx = clamp_step(mouse_pkt[MOUSE_X_SIGN_BIT],
			mouse_pkt[MOUSE_X_FIELD_LSB +: MOUSE_FIELD_W]);
		// y stays up positive here
		move_next.dy = clamp_step(mouse_pkt[MOUSE_Y_SIGN_BIT],
			mouse_pkt[MOUSE_Y_FIELD_LSB +: MOUSE_FIELD_W]);
	end

	// ========================================
	// output registers
	// ========================================

	// one cycle strobe per packet, no stall path
	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			move_stb <= 1'b0;
		end else begin
			move_stb <= pkt_new;
		end
	end

	// payload only loaded with a packet
	always_ff @(posedge clk_sys) begin
		if (pkt_new) begin
			move <= move_next;
		end
	end

endmodule

//--- logic/stick_pkg.sv
package stick_pkg;

	// ========================================
	// host side stick values
	// ========================================

	// two's complement axis, centre is zero
	typedef logic signed [7:0] stick_axis_t;

	// limits of the emulated position
	localparam int STICK_POS_MIN = -128;
	localparam int STICK_POS_MAX = 127;

	// one physical stick: digital button word plus analog axes
	typedef struct packed {
		logic [15:0] buttons;
		stick_axis_t x;
		stick_axis_t y;
	} stick_phys_t;

	// fire position in the button word
	localparam int FIRE_BIT = 4;

	// stick chosen for port 1, fire active high
	typedef struct packed {
		stick_axis_t x;
		stick_axis_t y;
		logic        fire;
	} stick_primary_t;

	// ========================================
	// computer core side
	// ========================================

	// unsigned, inverted offset code widened to 12 bits
	typedef logic [11:0] core_axis_t;

	typedef struct packed {
		core_axis_t x;
		core_axis_t y;
		logic       fire_n;
	} core_port_t;

	// centred axes, fire released
	localparam core_port_t CORE_PORT_IDLE = '{x: 12'h7F7, y: 12'h7F7, fire_n: 1'b1};

endpackage

//--- logic/mouse_pkg.sv
package mouse_pkg;

	// ========================================
	// ps/2 mouse packet as the host hands it over
	// ========================================

	// bit 24 flips once per new packet
	// bits 23:16 y movement byte, 15:8 x movement byte, 7:0 status byte
	typedef struct packed {
		logic       toggle;
		// y group, only the upper seven bits are used
		logic [6:0] y_move;
		logic       y_lsb;
		// x group, same split
		logic [6:0] x_move;
		logic       x_lsb;
		// status byte
		logic       y_ovf;
		logic       x_ovf;
		logic       y_sign;
		logic       x_sign;
		logic       always_one;
		logic       btn_mid;
		logic [1:0] buttons;
	} mouse_packet_t;

	// bit positions inside the flat 25-bit packet
	localparam int MOUSE_TOGGLE_BIT  = 24;
	localparam int MOUSE_Y_FIELD_LSB = 17;
	localparam int MOUSE_X_FIELD_LSB = 9;
	localparam int MOUSE_Y_SIGN_BIT  = 5;
	localparam int MOUSE_X_SIGN_BIT  = 4;
	// movement bits per axis, below the sign
	localparam int MOUSE_FIELD_W     = 7;

	// ========================================
	// decoded movement
	// ========================================

	// one axis delta, sign extended
	typedef logic signed [8:0] mouse_delta_t;

	// per packet movement, y still in mouse sense (up positive)
	typedef struct packed {
		mouse_delta_t dx;
		mouse_delta_t dy;
	} mouse_move_t;

	// largest step kept from a single packet
	localparam int MOUSE_STEP_LIMIT = 10;

endpackage
